//--- flist.f
hw/uart_pkg.sv
hw/debouncer.sv
hw/pattern_source.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/pattern_uart_top.sv
tb/tb_pattern_uart.sv

//--- hw/debouncer.sv
`timescale 1ns/1ps

module debouncer #(
    parameter int debounce_cycles = 100
) (
    input  logic clk,
    input  logic rst,
    input  logic sig_raw,
    output logic sig
);

    typedef logic [$clog2(debounce_cycles + 1) - 1:0] count_t;

    logic [1:0] sync;
    count_t     stable_count;

    // the switch is asynchronous to clk, so it passes two flops first.
    always_ff @(posedge clk) begin
        if (rst) begin
            sync         <= '0;
            sig          <= 1'b0;
            stable_count <= '0;
        end else begin
            sync <= {sync[0], sig_raw};
            if (sync[1] == sig) begin
                stable_count <= '0;
            end else if (stable_count == count_t'(debounce_cycles - 1)) begin
                // the new level has now held for debounce_cycles cycles in a row.
                sig          <= sync[1];
                stable_count <= '0;
            end else begin
                stable_count <= stable_count + 1'b1;
            end
        end
    end

endmodule

//--- hw/pattern_source.sv
`timescale 1ns/1ps

module pattern_source #(
    parameter int tick_width = 22
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic             ready,
    output uart_pkg::byte_t  data,
    output logic             valid,
    output uart_pkg::pattern_t pattern
);

    import uart_pkg::*;

    pattern_t      table_mem [pattern_depth];
    pattern_addr_t addr;
    pattern_t      pattern_q;

    logic [tick_width-1:0] div_count;
    logic                  tick;

    initial begin
        $readmemh(pattern_file, table_mem);
    end

    // synchronous read port, one cycle behind any address change.
    always_ff @(posedge clk) begin
        pattern_q <= table_mem[addr];
    end

    // the divider restarts from zero each time playback is switched on.
    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    assign tick = enable && (&div_count);

    // valid doubles as the pending flag.
    // a tick that arrives while a byte waits is simply lost.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            addr  <= '0;
        end else begin
            if (valid && ready) begin
                valid <= 1'b0;
                addr  <= addr + 1'b1;
            end else if (tick && !valid) begin
                valid <= 1'b1;
            end
        end
    end

    // the address only moves on acceptance, so pattern_q is settled
    // by the time valid can rise again and stays put while it is high.
    assign data    = {byte_prefix, pattern_q};
    assign pattern = pattern_q;

endmodule

//--- hw/pattern_uart_top.sv
`timescale 1ns/1ps

module pattern_uart_top #(
    parameter int tick_width      = 22,
    parameter int debounce_cycles = 100
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               sw_raw,
    input  logic               uart_txd_in,
    output uart_pkg::pattern_t led,
    output logic               uart_rxd_out,
    output logic               sw,
    output logic               tx_ready,
    output uart_pkg::byte_t    rx_data,
    output logic               rx_valid,
    output logic               rx_break,
    output logic               rx_error
);

    import uart_pkg::*;

    byte_t tx_data;
    logic  tx_valid;

    debouncer #(
        .debounce_cycles(debounce_cycles)
    ) i_debouncer (
        .clk(clk), .rst(rst),
        .sig_raw(sw_raw), .sig(sw)
    );

    pattern_source #(
        .tick_width(tick_width)
    ) i_pattern_source (
        .clk(clk), .rst(rst),
        .enable(sw), .ready(tx_ready),
        .data(tx_data), .valid(tx_valid),
        .pattern(led)
    );

    uart_tx #(
        .bit_cycles(clock_divider)
    ) i_uart_tx (
        .clk(clk), .rst(rst),
        .data(tx_data), .valid(tx_valid),
        .ready(tx_ready), .serial_out(uart_rxd_out)
    );

    // the receive path runs on its own and shares nothing with the player.
    uart_rx #(
        .bit_cycles(clock_divider)
    ) i_uart_rx (
        .clk(clk), .rst(rst),
        .serial_in(uart_txd_in),
        .data(rx_data), .valid(rx_valid),
        .break_received(rx_break), .error(rx_error)
    );

endmodule

//--- hw/uart_pkg.sv
package uart_pkg;

    // serial payload and pattern widths.
    typedef logic [7:0] byte_t;
    typedef logic [3:0] pattern_t;
    typedef logic [3:0] pattern_addr_t;

    // counts clock cycles inside one bit period.
    typedef logic [15:0] baud_count_t;

    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop
    } rx_state_t;

    localparam int clock_hz = 8_000_000;
    localparam int baud_rate = 115200;

    // rounded up, so the line runs slightly slow rather than fast.
    localparam int clock_divider = (clock_hz + baud_rate - 1) / baud_rate;

    localparam int pattern_depth = 16;

    // upper nibble of every transmitted byte, which makes the patterns printable.
    localparam pattern_t byte_prefix = 4'h4;

    localparam string pattern_file = "pattern.mem";

endpackage

//--- hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int bit_cycles = uart_pkg::clock_divider
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            serial_in,
    output uart_pkg::byte_t data,
    output logic            valid,
    output logic            break_received,
    output logic            error
);

    import uart_pkg::*;

    rx_state_t   state;
    baud_count_t baud_count;
    logic [2:0]  bit_index;
    logic [2:0]  sync;
    byte_t       shift_reg;
    logic        rx_bit;
    logic        half_end;
    logic        bit_end;

    // sync[2] is kept only to spot the falling edge of the start bit.
    assign rx_bit   = sync[1];
    assign half_end = (baud_count == baud_count_t'(bit_cycles / 2 - 1));
    assign bit_end  = (baud_count == baud_count_t'(bit_cycles - 1));

    always_ff @(posedge clk) begin
        if (state == rx_st_data && bit_end) begin
            shift_reg <= {rx_bit, shift_reg[7:1]};
        end
        if (state == rx_st_stop && bit_end) begin
            data <= shift_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sync           <= '1;
            state          <= rx_st_idle;
            baud_count     <= '0;
            bit_index      <= '0;
            valid          <= 1'b0;
            break_received <= 1'b0;
            error          <= 1'b0;
        end else begin
            sync           <= {sync[1:0], serial_in};
            valid          <= 1'b0;
            break_received <= 1'b0;
            error          <= 1'b0;
            baud_count     <= bit_end ? '0 : baud_count + 1'b1;
            case (state)
                rx_st_idle: begin
                    baud_count <= '0;
                    if (sync[2] && !rx_bit) begin
                        state <= rx_st_start;
                    end
                end
                rx_st_start: begin
                    // a short low glitch is not a start bit.
                    if (half_end) begin
                        baud_count <= '0;
                        bit_index  <= '0;
                        state      <= rx_bit ? rx_st_idle : rx_st_data;
                    end
                end
                rx_st_data: begin
                    if (bit_end) begin
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= rx_st_stop;
                        end
                    end
                end
                rx_st_stop: begin
                    if (bit_end) begin
                        // a low stop bit after all-zero data means the line is held low.
                        if (rx_bit) begin
                            valid <= 1'b1;
                        end else if (shift_reg == '0) begin
                            break_received <= 1'b1;
                        end else begin
                            error <= 1'b1;
                        end
                        state <= rx_st_idle;
                    end
                end
                default: state <= rx_st_idle;
            endcase
        end
    end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int bit_cycles = uart_pkg::clock_divider
) (
    input  logic            clk,
    input  logic            rst,
    input  uart_pkg::byte_t data,
    input  logic            valid,
    output logic            ready,
    output logic            serial_out
);

    import uart_pkg::*;

    tx_state_t   state;
    baud_count_t baud_count;
    logic [2:0]  bit_index;
    byte_t       shift_reg;
    logic        bit_end;
    logic        shift_en;

    assign ready    = (state == tx_st_idle);
    assign bit_end  = (baud_count == baud_count_t'(bit_cycles - 1));
    assign shift_en = bit_end && ((state == tx_st_start) ||
                                  (state == tx_st_data && bit_index != 3'd7));

    // LSB goes out first, so the register shifts right.
    always_ff @(posedge clk) begin
        if (ready && valid) begin
            shift_reg <= data;
        end else if (shift_en) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= tx_st_idle;
            serial_out <= 1'b1;
            baud_count <= '0;
            bit_index  <= '0;
        end else begin
            baud_count <= bit_end ? '0 : baud_count + 1'b1;
            case (state)
                tx_st_idle: begin
                    baud_count <= '0;
                    if (valid) begin
                        serial_out <= 1'b0;
                        state      <= tx_st_start;
                    end
                end
                tx_st_start: begin
                    if (bit_end) begin
                        serial_out <= shift_reg[0];
                        bit_index  <= '0;
                        state      <= tx_st_data;
                    end
                end
                tx_st_data: begin
                    if (bit_end) begin
                        if (bit_index == 3'd7) begin
                            serial_out <= 1'b1;
                            state      <= tx_st_stop;
                        end else begin
                            serial_out <= shift_reg[0];
                            bit_index  <= bit_index + 1'b1;
                        end
                    end
                end
                tx_st_stop: begin
                    if (bit_end) begin
                        state <= tx_st_idle;
                    end
                end
                default: state <= tx_st_idle;
            endcase
        end
    end

endmodule

//--- pattern.mem
// one hex pattern nibble per line, table entries 0 to 15 in order
1
2
4
8
8
4
2
1
3
6
c
9
f
0
a
5

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module tb_pattern_uart -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "run_sim: simulation reported a failure"
    exit 1
fi
echo "run_sim: no failure found in sim.log"

//--- tb/tb_pattern_uart.sv
`timescale 1ns/1ps

module tb_pattern_uart;

    import uart_pkg::*;

    localparam int tick_width      = 6;
    localparam int debounce_cycles = 8;
    localparam int tx_frames       = 20;
    localparam int rx_frames       = 30;
    localparam int max_gap         = 100;
    localparam int frame_cycles    = 10 * clock_divider;
    localparam int timeout_cycles  = (tx_frames + 4 + rx_frames + 3) * frame_cycles
                                     + rx_frames * max_gap + 2000;

    logic     clk = 1'b0;
    logic     rst;
    logic     sw_raw;
    logic     uart_txd_in;
    pattern_t led;
    logic     uart_rxd_out;
    logic     sw;
    logic     tx_ready;
    byte_t    rx_data;
    logic     rx_valid;
    logic     rx_break;
    logic     rx_error;

    pattern_t table_model [pattern_depth];
    int       error_count = 0;
    int       errors_at_start = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       cycle_count = 0;
    int       frames_started = 0;
    int       frames_done = 0;
    int       valid_count = 0;
    int       break_count = 0;
    int       error_pulses = 0;
    int       marks [3];
    byte_t    last_rx_data;

    pattern_uart_top #(
        .tick_width(tick_width),
        .debounce_cycles(debounce_cycles)
    ) i_pattern_uart_top (
        .clk(clk), .rst(rst), .sw_raw(sw_raw), .uart_txd_in(uart_txd_in),
        .led(led), .uart_rxd_out(uart_rxd_out), .sw(sw), .tx_ready(tx_ready),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_break(rx_break), .rx_error(rx_error)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_pattern(input string name, input pattern_t got, input pattern_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("failure at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
            tests_failed++;
        end
        errors_at_start = error_count;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // while the switch is still off the line must stay idle.
    task automatic idle_cycles_checked(input int n);
        repeat (n) begin
            wait_cycles(1);
            check_bit("sw", sw, 1'b0);
            check_bit("uart_rxd_out", uart_rxd_out, 1'b1);
        end
    endtask

    task automatic send_serial(input byte_t value, input logic stop_bit);
        uart_txd_in = 1'b0;
        wait_cycles(clock_divider);
        for (int i = 0; i < 8; i++) begin
            uart_txd_in = value[i];
            wait_cycles(clock_divider);
        end
        uart_txd_in = stop_bit;
        wait_cycles(clock_divider);
        uart_txd_in = 1'b1;
    endtask

    task automatic mark_rx_counts();
        marks[0] = valid_count;
        marks[1] = break_count;
        marks[2] = error_pulses;
    endtask

    task automatic check_rx_counts(input int exp_valid, input int exp_break, input int exp_error);
        if (valid_count - marks[0] != exp_valid || break_count - marks[1] != exp_break ||
            error_pulses - marks[2] != exp_error) begin
            note_failure($sformatf(
                "receiver pulses valid/break/error were %0d/%0d/%0d, not %0d/%0d/%0d",
                valid_count - marks[0], break_count - marks[1], error_pulses - marks[2],
                exp_valid, exp_break, exp_error));
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (rx_valid === 1'b1) begin
                valid_count++;
                last_rx_data = rx_data;
            end
            if (rx_break === 1'b1) begin
                break_count++;
            end
            if (rx_error === 1'b1) begin
                error_pulses++;
            end
        end
    end

    // decodes uart_rxd_out at bit centres; frame k must carry table entry k mod 16.
    initial begin : line_decoder
        byte_t    frame_byte;
        pattern_t led_at_start;
        int       idx;
        forever begin
            @(negedge clk);
            if (rst === 1'b0 && uart_rxd_out === 1'b0) begin
                idx = frames_started % pattern_depth;
                frames_started++;
                led_at_start = led;
                wait_cycles(clock_divider / 2);
                check_bit("uart_rxd_out start bit", uart_rxd_out, 1'b0);
                check_bit("tx_ready in start bit", tx_ready, 1'b0);
                for (int i = 0; i < 8; i++) begin
                    wait_cycles(clock_divider);
                    frame_byte[i] = uart_rxd_out;
                end
                wait_cycles(clock_divider);
                check_bit("uart_rxd_out stop bit", uart_rxd_out, 1'b1);
                check_bit("tx_ready in stop bit", tx_ready, 1'b0);
                check_pattern("led at frame start", led_at_start, table_model[idx]);
                check_byte("uart_rxd_out frame", frame_byte, {4'h4, table_model[idx]});
                frames_done++;
            end
        end
    end

    initial begin
        int    len;
        int    delay;
        int    snap;
        byte_t value;
        void'($urandom(32'h3f6a_087e));
        rst = 1'b1;
        sw_raw = 1'b0;
        uart_txd_in = 1'b1;
        $readmemh("pattern.mem", table_model);
        wait_cycles(10);
        rst = 1'b0;

        check_bit("uart_rxd_out", uart_rxd_out, 1'b1);
        check_bit("tx_ready", tx_ready, 1'b1);
        check_bit("rx_valid", rx_valid, 1'b0);
        check_bit("rx_error", rx_error, 1'b0);
        check_bit("rx_break", rx_break, 1'b0);
        check_bit("sw", sw, 1'b0);
        wait_cycles(1);
        check_pattern("led", led, table_model[0]);
        finish_test("reset state");

        for (int g = 0; g < 20; g++) begin
            len = 1 + int'($urandom % (debounce_cycles - 1));
            sw_raw = 1'b1;
            idle_cycles_checked(len);
            sw_raw = 1'b0;
            idle_cycles_checked(1 + int'($urandom % 10));
        end
        idle_cycles_checked(4);
        sw_raw = 1'b1;
        delay = 0;
        while (sw !== 1'b1 && delay < debounce_cycles + 10) begin
            wait_cycles(1);
            delay++;
        end
        // two synchronizer flops come on top of the stability count.
        if (delay < debounce_cycles || delay > debounce_cycles + 3) begin
            note_failure($sformatf("sw rose %0d cycles after the switch settled", delay));
        end
        finish_test("debounce");

        while (frames_done < tx_frames) begin
            wait_cycles(1);
        end
        finish_test("transmit sequence");

        // ticks come every 64 cycles against 700-cycle frames, so most are dropped.
        sw_raw = 1'b0;
        while (sw !== 1'b0) begin
            wait_cycles(1);
        end
        snap = frames_started;
        wait_cycles(2 * frame_cycles + 20);
        // the frame in flight ends and a byte already pending still goes out.
        if (frames_started - snap > 1) begin
            note_failure($sformatf("%0d frames started after sw fell", frames_started - snap));
        end
        snap = frames_started;
        wait_cycles(frame_cycles + 100);
        if (frames_started != snap || frames_done != frames_started) begin
            note_failure("the transmitter kept sending after playback stopped");
        end
        check_bit("tx_ready", tx_ready, 1'b1);
        check_bit("uart_rxd_out", uart_rxd_out, 1'b1);
        finish_test("back-pressure and stop");

        for (int n = 0; n < rx_frames; n++) begin
            value = byte_t'($urandom);
            mark_rx_counts();
            send_serial(value, 1'b1);
            check_rx_counts(1, 0, 0);
            check_byte("rx_data", last_rx_data, value);
            wait_cycles(1 + int'($urandom % max_gap));
        end
        finish_test("receive");

        mark_rx_counts();
        send_serial(byte_t'($urandom) | 8'h01, 1'b0);
        check_rx_counts(0, 0, 1);
        wait_cycles(20);
        mark_rx_counts();
        send_serial(8'h00, 1'b0);
        check_rx_counts(0, 1, 0);
        wait_cycles(20);
        value = byte_t'($urandom);
        mark_rx_counts();
        send_serial(value, 1'b1);
        check_rx_counts(1, 0, 0);
        check_byte("rx_data", last_rx_data, value);
        finish_test("receive faults");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
